/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = core_port_tb
FILELIST = core_port.f
BUILD_DIR = obj_dir
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# status follows the pass line in the simulation output
run: compile
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* core_port.f */
logic/noc_port_pkg.sv
logic/flit_serializer.sv
logic/flit_fifo.sv
logic/flit_deserializer.sv
logic/core_port.sv
tests/core_port_tb.sv

/* logic/core_port.sv */
`timescale 1ns/1ps

module core_port #(
	parameter int tx_depth = 4,
	parameter int rx_depth = 4
) (
	input  logic                               clk,
	input  logic                               reset,
	// core injection
	input  logic [noc_port_pkg::WORD_W-1:0]    core_in_word,
	input  logic                               core_in_valid,
	output logic                               core_in_ready,
	// router link out
	output logic [noc_port_pkg::FLIT_W-1:0]    tx_flit,
	output logic                               tx_valid,
	input  logic                               tx_ready,
	// router link in
	input  logic [noc_port_pkg::FLIT_W-1:0]    rx_flit,
	input  logic                               rx_valid,
	output logic                               rx_ready,
	// core ejection
	output logic [noc_port_pkg::ROUTE_W-1:0]   core_out_route,
	output logic [noc_port_pkg::PAYLOAD_W-1:0] core_out_payload,
	output logic                               core_out_valid,
	input  logic                               core_out_ready
);
	import noc_port_pkg::*;

	logic [FLIT_W-1:0] ser_flit; // serializer to tx fifo
	logic              ser_valid;
	logic              ser_ready;
	logic [FLIT_W-1:0] des_flit; // rx fifo to deserializer
	logic              des_valid;
	logic              des_ready;

	////////////////////////////////////////
	// injection path
	////////////////////////////////////////
	flit_serializer ser0 (
		.clk(clk), .reset(reset),
		.in_word(core_in_word), .in_valid(core_in_valid), .in_ready(core_in_ready),
		.flit(ser_flit), .flit_valid(ser_valid), .flit_ready(ser_ready)
	);

	flit_fifo #(.depth(tx_depth)) tx_fifo (
		.clk(clk), .reset(reset),
		.wr_flit(ser_flit), .wr_valid(ser_valid), .wr_ready(ser_ready),
		.rd_flit(tx_flit), .rd_valid(tx_valid), .rd_ready(tx_ready)
	);

	////////////////////////////////////////
	// ejection path
	////////////////////////////////////////
	flit_fifo #(.depth(rx_depth)) rx_fifo (
		.clk(clk), .reset(reset),
		.wr_flit(rx_flit), .wr_valid(rx_valid), .wr_ready(rx_ready),
		.rd_flit(des_flit), .rd_valid(des_valid), .rd_ready(des_ready)
	);

	flit_deserializer des0 (
		.clk(clk), .reset(reset),
		.flit(des_flit), .flit_valid(des_valid), .flit_ready(des_ready),
		.route(core_out_route), .payload(core_out_payload),
		.word_valid(core_out_valid), .word_ready(core_out_ready)
	);

endmodule

/* logic/flit_deserializer.sv */
`timescale 1ns/1ps

module flit_deserializer (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [noc_port_pkg::FLIT_W-1:0]    flit,
	input  logic                               flit_valid,
	output logic                               flit_ready,
	output logic [noc_port_pkg::ROUTE_W-1:0]   route,
	output logic [noc_port_pkg::PAYLOAD_W-1:0] payload,
	output logic                               word_valid,
	input  logic                               word_ready
);
	import noc_port_pkg::*;

	des_state_t state;
	des_state_t state_next;

	logic               flit_move;
	logic [SLICE_W-1:0] slice; // upper bits of the flit
	logic               tail;

	assign slice = flit[FLIT_W-1 -: SLICE_W];
	assign tail = flit[TAIL_BIT];

	// stop taking flits while a finished word sits unclaimed
	assign flit_ready = !word_valid || word_ready;
	assign flit_move = flit_valid && flit_ready;

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_comb begin
		state_next = state;
		if (flit_move) begin
			case (state)
				des_wait_header: state_next = des_data0;
				des_data0:       state_next = des_data1;
				des_data1:       state_next = des_data2;
				des_data2:       state_next = tail ? des_wait_header : des_data0; // packet goes on
				default:         state_next = des_wait_header;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= des_wait_header;
			word_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (flit_move && state == des_data2)
				word_valid <= 1'b1; // word complete
			else if (word_ready)
				word_valid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// route and payload gather
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (flit_move) begin
			case (state)
				des_wait_header: route <= slice; // kept for the whole packet
				des_data0:       payload[PAYLOAD_W-1 -: SLICE_W] <= slice;
				des_data1:       payload[2*SLICE_W-1 -: SLICE_W] <= slice;
				des_data2:       payload[SLICE_W-1:0] <= slice;
				default:         route <= route;
			endcase
		end
	end

	// serializer only sets the tail on the last slice
	a_tail_in_data2: assert property (@(posedge clk) disable iff (reset)
		flit_move && tail |-> state == des_data2);

endmodule

/* logic/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo #(
	parameter int depth = 4
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [noc_port_pkg::FLIT_W-1:0] wr_flit,
	input  logic                            wr_valid,
	output logic                            wr_ready,
	output logic [noc_port_pkg::FLIT_W-1:0] rd_flit,
	output logic                            rd_valid,
	input  logic                            rd_ready
);
	import noc_port_pkg::*;

	localparam int ptr_w = $clog2(depth); // depth is a power of two, pointers wrap
	localparam int cnt_w = $clog2(depth + 1);

	logic [FLIT_W-1:0] mem [depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;
	logic [cnt_w-1:0]  count_next;
	logic              full; // registered
	logic              empty; // registered
	logic              wr_en;
	logic              rd_en;

	assign wr_ready = !full;
	assign rd_valid = !empty;
	assign rd_flit = mem[rd_ptr]; // head of queue
	assign wr_en = wr_valid && !full;
	assign rd_en = rd_ready && !empty;

	always_comb begin
		count_next = count;
		if (wr_en && !rd_en)
			count_next = count + 1'b1;
		else if (!wr_en && rd_en)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			full <= (count_next == cnt_w'(depth)); // flags from next count
			empty <= (count_next == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_flit;
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= cnt_w'(depth));

endmodule

/* logic/flit_serializer.sv */
`timescale 1ns/1ps

module flit_serializer (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [noc_port_pkg::WORD_W-1:0]   in_word,
	input  logic                              in_valid,
	output logic                              in_ready,
	output logic [noc_port_pkg::FLIT_W-1:0]   flit,
	output logic                              flit_valid,
	input  logic                              flit_ready
);
	import noc_port_pkg::*;

	ser_state_t state;
	ser_state_t state_next;

	logic [ROUTE_W-1:0]   route; // route of the word in flight
	logic [PAYLOAD_W-1:0] payload; // low 30 bits of that word
	logic [ROUTE_W-1:0]   in_route; // route of the word waiting at the input
	logic                 coalesce;
	logic                 flit_move;
	logic                 capture;

	assign in_route = in_word[WORD_W-1 -: ROUTE_W];

	// same destination so the next word rides in the open packet
	assign coalesce = in_valid && (in_route == route);

	assign flit_valid = (state != ser_idle);
	assign flit_move = flit_valid && flit_ready;

	// words are taken when idle or as the last slice leaves
	assign capture = in_valid && ((state == ser_idle) || (state == ser_data2 && flit_move));
	assign in_ready = capture;

	////////////////////////////////////////
	// flit select
	////////////////////////////////////////
	always_comb begin
		case (state)
			ser_header: flit = {route, 1'b0}; // header never carries a tail
			ser_data0:  flit = {payload[PAYLOAD_W-1 -: SLICE_W], 1'b0}; // msb slice
			ser_data1:  flit = {payload[2*SLICE_W-1 -: SLICE_W], 1'b0};
			ser_data2:  flit = {payload[SLICE_W-1:0], !coalesce}; // tail closes the packet
			default:    flit = '0; // nothing offered in idle
		endcase
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			ser_idle: begin
				if (in_valid)
					state_next = ser_header;
			end
			ser_header: begin
				if (flit_move)
					state_next = ser_data0;
			end
			ser_data0: begin
				if (flit_move)
					state_next = ser_data1;
			end
			ser_data1: begin
				if (flit_move)
					state_next = ser_data2;
			end
			ser_data2: begin
				if (flit_move) begin
					if (coalesce)
						state_next = ser_data0; // skip the header
					else if (in_valid)
						state_next = ser_header; // new packet
					else
						state_next = ser_idle;
				end
			end
			default: state_next = ser_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ser_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			route <= in_route;
			payload <= in_word[PAYLOAD_W-1:0];
		end
	end

	// nothing goes out before a word is captured
	a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
		$rose(flit_valid) |-> $past(capture));

	// stalled flit keeps its slice while the tail may drop for a same-route word
	a_hold_flit: assert property (@(posedge clk) disable iff (reset)
		flit_valid && !flit_ready |=> flit_valid && $stable(flit[FLIT_W-1:1]));

endmodule

/* logic/noc_port_pkg.sv */
package noc_port_pkg;

	////////////////////////////////////////
	// core word  [ route | code | data ]
	////////////////////////////////////////
	localparam int ROUTE_W = 10;
	localparam int CODE_W = 8;
	localparam int DATA_W = 24;
	localparam int WORD_W = ROUTE_W + CODE_W + DATA_W; // 42 bits

	////////////////////////////////////////
	// router flit  [ route or slice | tail ]
	////////////////////////////////////////
	localparam int FLIT_W = 11;
	localparam int SLICE_W = FLIT_W - 1; // payload bits per data flit
	localparam int TAIL_BIT = 0;
	localparam int DATA_FLITS = 3;

	// only the low part of a word is routed, code msbs fall off
	localparam int PAYLOAD_W = DATA_FLITS * SLICE_W;

	// injection side
	typedef enum logic [2:0] {
		ser_idle,
		ser_header,
		ser_data0,
		ser_data1,
		ser_data2
	} ser_state_t;

	// ejection side
	typedef enum logic [1:0] {
		des_wait_header,
		des_data0,
		des_data1,
		des_data2
	} des_state_t;

endpackage

/* tests/core_port_tb.sv */
`timescale 1ns/1ps

module core_port_tb;
	import noc_port_pkg::*;

	localparam int total_words = 41; // 1 + 8 + 8 + 12 + 12
	localparam int watchdog_cycles = total_words * 40 + 200;

	logic                 clk = 1'b0;
	logic                 reset = 1'b1;
	logic [WORD_W-1:0]    core_in_word = '0;
	logic                 core_in_valid = 1'b0;
	logic                 core_in_ready;
	logic [FLIT_W-1:0]    tx_flit;
	logic                 tx_valid;
	logic                 tx_ready;
	logic [FLIT_W-1:0]    rx_flit;
	logic                 rx_valid;
	logic                 rx_ready;
	logic [ROUTE_W-1:0]   core_out_route;
	logic [PAYLOAD_W-1:0] core_out_payload;
	logic                 core_out_valid;
	logic                 core_out_ready = 1'b1;

	logic        stall = 1'b0; // link gate, holds tx and rx together
	logic        stall_en = 1'b0;
	logic        out_bp_en = 1'b0;
	logic [31:0] lfsr = 32'hbbf9_28eb;
	int          errors = 0;
	int          checks = 0;

	logic [WORD_W-1:0]            stim[$]; // words for the current test
	logic [FLIT_W-1:0]            exp_flits[$];
	logic [ROUTE_W+PAYLOAD_W-1:0] exp_words[$];
	logic [FLIT_W-1:0]            flit_seen[$]; // from the monitors
	logic [ROUTE_W+PAYLOAD_W-1:0] word_seen[$];

	logic                 held = 1'b0;
	logic [ROUTE_W-1:0]   held_route;
	logic [PAYLOAD_W-1:0] held_payload;

	always #2 clk = ~clk; // 4 ns period

	core_port #(.tx_depth(4), .rx_depth(4)) dut0 (
		.clk(clk), .reset(reset),
		.core_in_word(core_in_word), .core_in_valid(core_in_valid),
		.core_in_ready(core_in_ready),
		.tx_flit(tx_flit), .tx_valid(tx_valid), .tx_ready(tx_ready),
		.rx_flit(rx_flit), .rx_valid(rx_valid), .rx_ready(rx_ready),
		.core_out_route(core_out_route), .core_out_payload(core_out_payload),
		.core_out_valid(core_out_valid), .core_out_ready(core_out_ready)
	);

	////////////////////////////////////////
	// loopback through the stall gate
	////////////////////////////////////////
	assign rx_flit = tx_flit;
	assign rx_valid = tx_valid && !stall;
	assign tx_ready = rx_ready && !stall;

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]}; // one step per bit
		end
		return v;
	endfunction

	function automatic logic [ROUTE_W-1:0] random_route();
		logic [63:0] r;
		r = random_bits(ROUTE_W);
		return r[ROUTE_W-1:0];
	endfunction

	function automatic logic [WORD_W-1:0] make_word(input logic [ROUTE_W-1:0] route);
		logic [63:0] r;
		r = random_bits(CODE_W + DATA_W);
		return {route, r[CODE_W+DATA_W-1:0]};
	endfunction

	task automatic compare_values(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// back-pressure sources, change only on the falling edge
	always @(negedge clk) begin
		stall = stall_en ? (random_bits(1) == 64'd1) : 1'b0;
		core_out_ready = out_bp_en ? (random_bits(1) == 64'd1) : 1'b1;
	end

	////////////////////////////////////////
	// flit and word monitors
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!reset) begin
			if (held) begin // word stalled last cycle must not move
				compare_values("core_out_valid", 64'(core_out_valid), 64'd1);
				compare_values("core_out_route", 64'(core_out_route), 64'(held_route));
				compare_values("core_out_payload", 64'(core_out_payload), 64'(held_payload));
			end
			if (tx_valid && tx_ready)
				flit_seen.push_back(tx_flit);
			if (core_out_valid && core_out_ready)
				word_seen.push_back({core_out_route, core_out_payload});
			held = core_out_valid && !core_out_ready;
			held_route = core_out_route;
			held_payload = core_out_payload;
		end
	end

	// flit stream and returned words from the packet rules
	task automatic build_expected();
		logic [ROUTE_W-1:0]   r;
		logic [ROUTE_W-1:0]   prev;
		logic [PAYLOAD_W-1:0] p;
		logic                 last;
		exp_flits.delete();
		exp_words.delete();
		prev = '0;
		for (int i = 0; i < stim.size(); i++) begin
			r = stim[i][WORD_W-1 -: ROUTE_W];
			p = stim[i][PAYLOAD_W-1:0];
			if (i == stim.size() - 1)
				last = 1'b1; // valid drops after the final word
			else
				last = (stim[i+1][WORD_W-1 -: ROUTE_W] != r);
			if (i == 0 || r != prev)
				exp_flits.push_back({r, 1'b0}); // header
			exp_flits.push_back({p[3*SLICE_W-1 -: SLICE_W], 1'b0});
			exp_flits.push_back({p[2*SLICE_W-1 -: SLICE_W], 1'b0});
			exp_flits.push_back({p[SLICE_W-1:0], last});
			exp_words.push_back({r, p});
			prev = r;
		end
	endtask

	// called on a falling edge, returns on the next one after the handshake
	task automatic send_word(input logic [WORD_W-1:0] w);
		core_in_word = w;
		core_in_valid = 1'b1;
		@(posedge clk);
		while (!core_in_ready)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic run_and_check(input string label);
		build_expected();
		flit_seen.delete();
		word_seen.delete();
		foreach (stim[i])
			send_word(stim[i]); // valid stays high across words
		core_in_valid = 1'b0;
		while (word_seen.size() < exp_words.size())
			@(negedge clk);
		repeat (10) @(negedge clk); // catch extra flits or words
		compare_values({label, " tx flit count"}, 64'(flit_seen.size()), 64'(exp_flits.size()));
		compare_values({label, " word count"}, 64'(word_seen.size()), 64'(exp_words.size()));
		for (int i = 0; i < exp_flits.size() && i < flit_seen.size(); i++)
			compare_values($sformatf("%s tx_flit[%0d]", label, i), 64'(flit_seen[i]),
				64'(exp_flits[i]));
		for (int i = 0; i < exp_words.size() && i < word_seen.size(); i++)
			compare_values($sformatf("%s core_out[%0d]", label, i), 64'(word_seen[i]),
				64'(exp_words[i]));
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////
	task automatic check_reset_state();
		compare_values("core_in_ready", 64'(core_in_ready), 64'd0);
		compare_values("tx_valid", 64'(tx_valid), 64'd0);
		compare_values("core_out_valid", 64'(core_out_valid), 64'd0);
		compare_values("rx_ready", 64'(rx_ready), 64'd1); // rx fifo empty
	endtask

	task automatic single_word();
		stim.delete();
		stim.push_back(make_word(random_route()));
		run_and_check("single");
	endtask

	task automatic same_route_run();
		logic [ROUTE_W-1:0] r;
		r = random_route();
		stim.delete();
		repeat (8) stim.push_back(make_word(r)); // one packet, one header
		run_and_check("same_route");
	endtask

	task automatic route_changes();
		logic [ROUTE_W-1:0] ra;
		logic [ROUTE_W-1:0] rb;
		ra = random_route();
		rb = ra ^ 10'h155; // always differs from ra
		stim.delete();
		for (int i = 0; i < 8; i++)
			stim.push_back(make_word(i[0] ? rb : ra));
		run_and_check("route_change");
	endtask

	task automatic tx_backpressure();
		logic [ROUTE_W-1:0] ra;
		logic [ROUTE_W-1:0] rb;
		ra = random_route();
		rb = ra ^ 10'h2a3;
		stim.delete();
		for (int i = 0; i < 12; i++) // mix of runs and changes
			stim.push_back(make_word((random_bits(1) == 64'd1) ? ra : rb));
		stall_en = 1'b1;
		run_and_check("tx_bp");
		stall_en = 1'b0;
	endtask

	task automatic out_backpressure();
		logic [ROUTE_W-1:0] r;
		r = random_route();
		stim.delete();
		for (int i = 0; i < 12; i++) begin
			if (random_bits(1) == 64'd1)
				r = random_route(); // sometimes a new destination
			stim.push_back(make_word(r));
		end
		out_bp_en = 1'b1;
		run_and_check("out_bp");
		out_bp_en = 1'b0;
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

	initial begin
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_reset_state();
		single_word();
		same_route_run();
		route_changes();
		tx_backpressure();
		out_backpressure();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
